// File: source/dnoc_itf_out.sv
`timescale 1ns/1ps

`include "dnoc_macros.svh"

module dnoc_itf_out #(
    parameter logic [`DNOC_NODE_ID_W-1:0] NODE_ID = '0
) (
    input  logic                            clk,
    input  logic                            rst_i,

    // read requests
    input  dnoc_pkg::dnoc_rd_cmd_t          rd_cmd_i,
    input  logic                            rd_cmd_valid_i,
    output logic                            rd_cmd_ready_o,

    // write commands and payload
    input  dnoc_pkg::dnoc_wr_cmd_t          wr_cmd_i,
    input  logic                            wr_cmd_valid_i,
    output logic                            wr_cmd_ready_o,
    input  logic [`DNOC_FLIT_W-1:0]         wr_data_i,
    input  logic                            wr_data_valid_i,
    output logic                            wr_data_ready_o,

    // local router port
    output dnoc_pkg::dnoc_link_t            node_in_link_o,
    output logic [`DNOC_VC_NUM-1:0]         node_in_valid_o,
    input  logic [`DNOC_VC_NUM-1:0]         node_in_ready_i
);

    import dnoc_pkg::*;

    dnoc_link_t [`DNOC_VC_NUM-1:0]  ch_link;
    logic [`DNOC_VC_NUM-1:0]        ch_valid;
    logic [`DNOC_VC_NUM-1:0]        ch_ready;

    dnoc_out_c_channel #(
        .NODE_ID         (NODE_ID)
    ) u_out_c_channel (
        .clk             (clk),
        .rst_i           (rst_i),
        .rd_cmd_i        (rd_cmd_i),
        .rd_cmd_valid_i  (rd_cmd_valid_i),
        .rd_cmd_ready_o  (rd_cmd_ready_o),
        .link_o          (ch_link[`DNOC_VC_C]),
        .link_valid_o    (ch_valid[`DNOC_VC_C]),
        .link_ready_i    (ch_ready[`DNOC_VC_C])
    );

    dnoc_out_d_channel #(
        .NODE_ID         (NODE_ID)
    ) u_out_d_channel (
        .clk             (clk),
        .rst_i           (rst_i),
        .wr_cmd_i        (wr_cmd_i),
        .wr_cmd_valid_i  (wr_cmd_valid_i),
        .wr_cmd_ready_o  (wr_cmd_ready_o),
        .wr_data_i       (wr_data_i),
        .wr_data_valid_i (wr_data_valid_i),
        .wr_data_ready_o (wr_data_ready_o),
        .link_o          (ch_link[`DNOC_VC_D]),
        .link_valid_o    (ch_valid[`DNOC_VC_D]),
        .link_ready_i    (ch_ready[`DNOC_VC_D])
    );

    // both channels share the local port
    dnoc_vchannel_mux u_vc_mux (
        .clk             (clk),
        .rst_i           (rst_i),
        .in_link_i       (ch_link),
        .in_valid_i      (ch_valid),
        .in_ready_o      (ch_ready),
        .out_link_o      (node_in_link_o),
        .out_valid_o     (node_in_valid_o),
        .out_ready_i     (node_in_ready_i)
    );

endmodule

// File: source/dnoc_macros.svh
`ifndef DNOC_MACROS_SVH
`define DNOC_MACROS_SVH

// one flit on the local router port
`define DNOC_FLIT_W         256

// header field widths
`define DNOC_NODE_ID_W      4
`define DNOC_NOC_ADDR_W     25
`define DNOC_LEN_W          13

// virtual channels of the local port
`define DNOC_VC_NUM         2

// channel indices, data on 0 and control on 1
`define DNOC_VC_D           0
`define DNOC_VC_C           1

`endif

// File: source/dnoc_out_c_channel.sv
`timescale 1ns/1ps

`include "dnoc_macros.svh"

module dnoc_out_c_channel #(
    parameter logic [`DNOC_NODE_ID_W-1:0] NODE_ID = '0
) (
    input  logic                    clk,
    input  logic                    rst_i,

    // read requests from the core
    input  dnoc_pkg::dnoc_rd_cmd_t  rd_cmd_i,
    input  logic                    rd_cmd_valid_i,
    output logic                    rd_cmd_ready_o,

    // control channel toward the mux
    output dnoc_pkg::dnoc_link_t    link_o,
    output logic                    link_valid_o,
    input  logic                    link_ready_i
);

    import dnoc_pkg::*;

    dnoc_hdr_t   hdr_d;
    dnoc_flit_u  flit_q;
    logic        link_valid_q;
    logic        rd_cmd_xfer;

    // take a request when the flit register is empty or drains now
    assign rd_cmd_ready_o = !link_valid_q || link_ready_i;
    assign rd_cmd_xfer    = rd_cmd_valid_i && rd_cmd_ready_o;

    // header built straight from the command
    always_comb begin
        hdr_d           = '0;
        hdr_d.kind      = PKT_RD_REQ;
        hdr_d.src_id    = NODE_ID;
        hdr_d.tgt_id    = rd_cmd_i.tgt_id;
        hdr_d.base_addr = rd_cmd_i.base_addr;
        hdr_d.len       = rd_cmd_i.len;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            link_valid_q <= 1'b0;
        end else if (rd_cmd_ready_o) begin
            // refill or go empty, held while stalled
            link_valid_q <= rd_cmd_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_cmd_xfer) begin
            flit_q.hdr <= hdr_d;
        end
    end

    // a read request is always a single flit packet
    assign link_o.flit  = flit_q;
    assign link_o.last  = 1'b1;
    assign link_valid_o = link_valid_q;

endmodule

// File: source/dnoc_out_d_channel.sv
`timescale 1ns/1ps

`include "dnoc_macros.svh"

module dnoc_out_d_channel #(
    parameter logic [`DNOC_NODE_ID_W-1:0] NODE_ID = '0
) (
    input  logic                    clk,
    input  logic                    rst_i,

    // write command from the core
    input  dnoc_pkg::dnoc_wr_cmd_t  wr_cmd_i,
    input  logic                    wr_cmd_valid_i,
    output logic                    wr_cmd_ready_o,

    // payload words of the current write
    input  logic [`DNOC_FLIT_W-1:0] wr_data_i,
    input  logic                    wr_data_valid_i,
    output logic                    wr_data_ready_o,

    // data channel toward the mux
    output dnoc_pkg::dnoc_link_t    link_o,
    output logic                    link_valid_o,
    input  logic                    link_ready_i
);

    import dnoc_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_HDR  = 2'd1;
    localparam logic [1:0] ST_BODY = 2'd2;

    logic [1:0]             state_q;
    logic [1:0]             state_d;
    logic [`DNOC_LEN_W-1:0] remain_q;
    logic [`DNOC_LEN_W-1:0] remain_d;
    dnoc_hdr_t              hdr_d;
    dnoc_flit_u             hdr_q;
    logic                   wr_cmd_xfer;
    logic                   link_xfer;

    assign wr_cmd_ready_o = (state_q == ST_IDLE);
    assign wr_cmd_xfer    = wr_cmd_valid_i && wr_cmd_ready_o;
    assign link_xfer      = link_valid_o && link_ready_i;

    // payload ready only while words are still owed
    assign wr_data_ready_o = (state_q == ST_BODY) && link_ready_i;

    always_comb begin
        hdr_d           = '0;
        hdr_d.kind      = PKT_WR_DATA;
        hdr_d.src_id    = NODE_ID;
        hdr_d.tgt_id    = wr_cmd_i.tgt_id;
        hdr_d.base_addr = wr_cmd_i.base_addr;
        hdr_d.len       = wr_cmd_i.len;
    end

    // output side, header from register or payload passed through
    always_comb begin
        link_valid_o = 1'b0;
        link_o.flit  = hdr_q;
        // zero length write ends on the header
        link_o.last  = (remain_q == '0);
        case (state_q)
            ST_HDR: begin
                link_valid_o = 1'b1;
            end
            ST_BODY: begin
                link_valid_o    = wr_data_valid_i;
                link_o.flit.raw = wr_data_i;
                link_o.last     = (remain_q == 1);
            end
            default: begin
                link_valid_o = 1'b0;
            end
        endcase
    end

    always_comb begin
        state_d  = state_q;
        remain_d = remain_q;
        case (state_q)
            ST_IDLE: begin
                if (wr_cmd_xfer) begin
                    state_d  = ST_HDR;
                    remain_d = wr_cmd_i.len;
                end
            end
            ST_HDR: begin
                if (link_xfer) begin
                    state_d = link_o.last ? ST_IDLE : ST_BODY;
                end
            end
            ST_BODY: begin
                if (link_xfer) begin
                    remain_d = remain_q - 1'b1;
                    if (link_o.last) begin
                        state_d = ST_IDLE;
                    end
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q  <= ST_IDLE;
            remain_q <= '0;
        end else begin
            state_q  <= state_d;
            remain_q <= remain_d;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_cmd_xfer) begin
            hdr_q.hdr <= hdr_d;
        end
    end

endmodule

// File: source/dnoc_pkg.sv
`include "dnoc_macros.svh"

package dnoc_pkg;

    // packet kind carried in every header
    typedef enum logic [1:0] {
        PKT_RD_REQ  = 2'd1,
        PKT_WR_DATA = 2'd2
    } dnoc_pkt_e;

    // header bits left over after the used fields
    localparam int HDR_USED_W = $bits(dnoc_pkt_e) + 2 * `DNOC_NODE_ID_W
                                + `DNOC_NOC_ADDR_W + `DNOC_LEN_W;
    localparam int HDR_RSVD_W = `DNOC_FLIT_W - HDR_USED_W;

    // header flit layout
    typedef struct packed {
        dnoc_pkt_e                    kind;
        logic [`DNOC_NODE_ID_W-1:0]   src_id;
        logic [`DNOC_NODE_ID_W-1:0]   tgt_id;
        logic [`DNOC_NOC_ADDR_W-1:0]  base_addr;
        // payload flits that follow the header
        logic [`DNOC_LEN_W-1:0]       len;
        logic [HDR_RSVD_W-1:0]        rsvd;
    } dnoc_hdr_t;

    // one flit word, either a header or raw payload
    typedef union packed {
        dnoc_hdr_t                    hdr;
        logic [`DNOC_FLIT_W-1:0]      raw;
    } dnoc_flit_u;

    // flit plus end of packet marker
    typedef struct packed {
        dnoc_flit_u                   flit;
        logic                         last;
    } dnoc_link_t;

    // read request from the core
    typedef struct packed {
        logic [`DNOC_NODE_ID_W-1:0]   tgt_id;
        logic [`DNOC_NOC_ADDR_W-1:0]  base_addr;
        logic [`DNOC_LEN_W-1:0]       len;
    } dnoc_rd_cmd_t;

    // write command, payload words arrive separately
    typedef struct packed {
        logic [`DNOC_NODE_ID_W-1:0]   tgt_id;
        logic [`DNOC_NOC_ADDR_W-1:0]  base_addr;
        logic [`DNOC_LEN_W-1:0]       len;
    } dnoc_wr_cmd_t;

endpackage

// File: source/dnoc_vchannel_mux.sv
`timescale 1ns/1ps

`include "dnoc_macros.svh"

module dnoc_vchannel_mux (
    input  logic                                     clk,
    input  logic                                     rst_i,

    // one stream per virtual channel
    input  dnoc_pkg::dnoc_link_t [`DNOC_VC_NUM-1:0]  in_link_i,
    input  logic [`DNOC_VC_NUM-1:0]                  in_valid_i,
    output logic [`DNOC_VC_NUM-1:0]                  in_ready_o,

    // local router port
    output dnoc_pkg::dnoc_link_t                     out_link_o,
    output logic [`DNOC_VC_NUM-1:0]                  out_valid_o,
    input  logic [`DNOC_VC_NUM-1:0]                  out_ready_i
);

    localparam int CH_W = $clog2(`DNOC_VC_NUM);

    logic             lock_q;
    logic [CH_W-1:0]  lock_ch_q;
    // channel of the last finished packet
    logic [CH_W-1:0]  last_q;
    logic             gnt_vld;
    logic [CH_W-1:0]  gnt_ch;
    logic             out_xfer;

    // grant, locked channel first, else round robin after last_q
    always_comb begin
        logic [CH_W-1:0] cand;

        gnt_vld = 1'b0;
        gnt_ch  = lock_ch_q;
        cand    = last_q;
        if (lock_q) begin
            gnt_vld = in_valid_i[lock_ch_q];
        end else begin
            for (int k = 1; k <= `DNOC_VC_NUM; k++) begin
                cand = CH_W'((int'(last_q) + k) % `DNOC_VC_NUM);
                if (!gnt_vld && in_valid_i[cand]) begin
                    gnt_vld = 1'b1;
                    gnt_ch  = cand;
                end
            end
        end
    end

    assign out_xfer   = gnt_vld && out_ready_i[gnt_ch];
    assign out_link_o = in_link_i[gnt_ch];

    // single valid bit on the granted channel
    always_comb begin
        out_valid_o = '0;
        in_ready_o  = '0;
        if (gnt_vld) begin
            out_valid_o[gnt_ch] = 1'b1;
            in_ready_o[gnt_ch]  = out_ready_i[gnt_ch];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            lock_q    <= 1'b0;
            lock_ch_q <= '0;
            // control channel goes first after reset
            last_q    <= CH_W'(`DNOC_VC_D);
        end else if (out_xfer) begin
            // hold the channel until its last flit leaves
            lock_q    <= !out_link_o.last;
            lock_ch_q <= gnt_ch;
            if (out_link_o.last) begin
                last_q <= gnt_ch;
            end
        end
    end

endmodule

// File: tb.f
+incdir+source
source/dnoc_pkg.sv
source/dnoc_out_c_channel.sv
source/dnoc_out_d_channel.sv
source/dnoc_vchannel_mux.sv
source/dnoc_itf_out.sv
verif/tb_dnoc_itf_out.sv

// File: verif/tb_dnoc_itf_out.sv
`timescale 1ns/1ps

`include "dnoc_macros.svh"

module tb_dnoc_itf_out;

    import dnoc_pkg::*;

    localparam logic [`DNOC_NODE_ID_W-1:0] NODE_ID = 4'hA;
    localparam int CLK_PERIOD = 100;
    localparam int N_RD       = 24;
    localparam int N_WR       = 16;

    logic                           clk;
    logic                           rst_i;
    dnoc_rd_cmd_t                   rd_cmd_i;
    logic                           rd_cmd_valid_i;
    logic                           rd_cmd_ready_o;
    dnoc_wr_cmd_t                   wr_cmd_i;
    logic                           wr_cmd_valid_i;
    logic                           wr_cmd_ready_o;
    logic [`DNOC_FLIT_W-1:0]        wr_data_i;
    logic                           wr_data_valid_i;
    logic                           wr_data_ready_o;
    dnoc_link_t                     node_in_link_o;
    logic [`DNOC_VC_NUM-1:0]        node_in_valid_o;
    logic [`DNOC_VC_NUM-1:0]        node_in_ready_i;

    // commands and payload in issue order
    dnoc_rd_cmd_t             rd_q[$];
    dnoc_wr_cmd_t             wr_q[$];
    logic [`DNOC_FLIT_W-1:0]  data_q[$];

    // expected flits per channel
    dnoc_link_t  exp_c_q[$];
    dnoc_link_t  exp_d_q[$];
    bit          exp_d_hdr_q[$];

    int  mismatch_cnt = 0;
    int  other_cnt    = 0;
    int  total_flits  = 0;
    // data packet between header and last flit
    bit  d_open       = 1'b0;

    dnoc_itf_out #(
        .NODE_ID         (NODE_ID)
    ) i_dut (
        .clk             (clk),
        .rst_i           (rst_i),
        .rd_cmd_i        (rd_cmd_i),
        .rd_cmd_valid_i  (rd_cmd_valid_i),
        .rd_cmd_ready_o  (rd_cmd_ready_o),
        .wr_cmd_i        (wr_cmd_i),
        .wr_cmd_valid_i  (wr_cmd_valid_i),
        .wr_cmd_ready_o  (wr_cmd_ready_o),
        .wr_data_i       (wr_data_i),
        .wr_data_valid_i (wr_data_valid_i),
        .wr_data_ready_o (wr_data_ready_o),
        .node_in_link_o  (node_in_link_o),
        .node_in_valid_o (node_in_valid_o),
        .node_in_ready_i (node_in_ready_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // expected flit for a header or for payload word idx
    function automatic dnoc_link_t ref_flit(
        input bit                          is_hdr,
        input dnoc_pkt_e                   kind,
        input logic [`DNOC_NODE_ID_W-1:0]  tgt,
        input logic [`DNOC_NOC_ADDR_W-1:0] addr,
        input logic [`DNOC_LEN_W-1:0]      len,
        input logic [`DNOC_FLIT_W-1:0]     word,
        input int                          idx
    );
        dnoc_link_t l;

        l = '0;
        if (is_hdr) begin
            l.flit.hdr.kind      = kind;
            l.flit.hdr.src_id    = NODE_ID;
            l.flit.hdr.tgt_id    = tgt;
            l.flit.hdr.base_addr = addr;
            l.flit.hdr.len       = len;
            // reads are one flit and empty writes end on the header
            l.last = (kind == PKT_RD_REQ) || (len == 0);
        end else begin
            l.flit.raw = word;
            l.last     = (idx == int'(len) - 1);
        end
        return l;
    endfunction

    task automatic compare_hdr(input dnoc_hdr_t got, input dnoc_hdr_t exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t ns: %s header got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_payload(input dnoc_flit_u got, input dnoc_flit_u exp,
                                   input string what);
        if (got.raw !== exp.raw) begin
            mismatch_cnt++;
            $display("mismatch at %0t ns: %s payload got %h expected %h",
                     $time, what, got.raw, exp.raw);
        end
    endtask

    task automatic compare_last(input dnoc_link_t got, input dnoc_link_t exp, input string what);
        if (got.last !== exp.last) begin
            mismatch_cnt++;
            $display("mismatch at %0t ns: %s last got %b expected %b",
                     $time, what, got.last, exp.last);
        end
    endtask

    task automatic random_word(output logic [`DNOC_FLIT_W-1:0] word);
        for (int k = 0; k < `DNOC_FLIT_W / 32; k++) begin
            word[k*32 +: 32] = $urandom();
        end
    endtask

    task automatic build_stimulus();
        dnoc_rd_cmd_t             rc;
        dnoc_wr_cmd_t             wc;
        logic [`DNOC_FLIT_W-1:0]  word;

        for (int i = 0; i < N_RD; i++) begin
            rc.tgt_id    = $urandom();
            rc.base_addr = $urandom();
            rc.len       = $urandom();
            rd_q.push_back(rc);
            exp_c_q.push_back(ref_flit(1'b1, PKT_RD_REQ, rc.tgt_id, rc.base_addr,
                                       rc.len, '0, 0));
        end
        for (int i = 0; i < N_WR; i++) begin
            wc.tgt_id    = $urandom();
            wc.base_addr = $urandom();
            wc.len       = $urandom_range(8, 0);
            wr_q.push_back(wc);
            exp_d_q.push_back(ref_flit(1'b1, PKT_WR_DATA, wc.tgt_id, wc.base_addr,
                                       wc.len, '0, 0));
            exp_d_hdr_q.push_back(1'b1);
            for (int j = 0; j < int'(wc.len); j++) begin
                random_word(word);
                data_q.push_back(word);
                exp_d_q.push_back(ref_flit(1'b0, PKT_WR_DATA, wc.tgt_id, wc.base_addr,
                                           wc.len, word, j));
                exp_d_hdr_q.push_back(1'b0);
            end
        end
        total_flits = exp_c_q.size() + exp_d_q.size();
    endtask

    task automatic drive_reads();
        for (int i = 0; i < rd_q.size(); i++) begin
            if ($urandom_range(3, 0) == 0) begin
                rd_cmd_valid_i = 1'b0;
                @(negedge clk);
            end
            rd_cmd_i       = rd_q[i];
            rd_cmd_valid_i = 1'b1;
            do @(posedge clk); while (!rd_cmd_ready_o);
            @(negedge clk);
        end
        rd_cmd_valid_i = 1'b0;
    endtask

    task automatic drive_writes();
        int w;

        w = 0;
        for (int i = 0; i < wr_q.size(); i++) begin
            wr_cmd_i       = wr_q[i];
            wr_cmd_valid_i = 1'b1;
            do @(posedge clk); while (!wr_cmd_ready_o);
            @(negedge clk);
            wr_cmd_valid_i = 1'b0;
            for (int j = 0; j < int'(wr_q[i].len); j++) begin
                if ($urandom_range(3, 0) == 0) begin
                    wr_data_valid_i = 1'b0;
                    @(negedge clk);
                end
                wr_data_i       = data_q[w];
                wr_data_valid_i = 1'b1;
                do @(posedge clk); while (!wr_data_ready_o);
                @(negedge clk);
                wr_data_valid_i = 1'b0;
                w++;
            end
        end
    endtask

    // random router back-pressure per channel
    task automatic apply_backpressure();
        forever begin
            @(negedge clk);
            for (int v = 0; v < `DNOC_VC_NUM; v++) begin
                node_in_ready_i[v] = ($urandom_range(3, 0) != 0);
            end
        end
    endtask

    task automatic check_ctrl_flit(input dnoc_link_t got);
        dnoc_link_t exp_flit;

        if (exp_c_q.size() == 0) begin
            other_cnt++;
            $display("%0t ns: control flit arrived when none was expected", $time);
        end else begin
            exp_flit = exp_c_q.pop_front();
            if (d_open) begin
                other_cnt++;
                $display("%0t ns: control flit sent inside an open write packet", $time);
            end
            compare_hdr(got.flit.hdr, exp_flit.flit.hdr, "control");
            compare_last(got, exp_flit, "control");
        end
    endtask

    task automatic check_data_flit(input dnoc_link_t got);
        dnoc_link_t exp_flit;
        bit         is_hdr;

        if (exp_d_q.size() == 0) begin
            other_cnt++;
            $display("%0t ns: data flit arrived when none was expected", $time);
        end else begin
            exp_flit = exp_d_q.pop_front();
            is_hdr   = exp_d_hdr_q.pop_front();
            if (is_hdr) begin
                compare_hdr(got.flit.hdr, exp_flit.flit.hdr, "data");
            end else begin
                compare_payload(got.flit, exp_flit.flit, "data");
            end
            compare_last(got, exp_flit, "data");
            d_open = !exp_flit.last;
        end
    endtask

    // outputs are stable here since inputs only move on the falling edge
    always @(posedge clk) begin
        if (!rst_i) begin
            if ($countones(node_in_valid_o) > 1) begin
                other_cnt++;
                $display("%0t ns: more than one valid bit set on the local port (%b)",
                         $time, node_in_valid_o);
            end
            if (node_in_valid_o[`DNOC_VC_C] && node_in_ready_i[`DNOC_VC_C]) begin
                check_ctrl_flit(node_in_link_o);
            end
            if (node_in_valid_o[`DNOC_VC_D] && node_in_ready_i[`DNOC_VC_D]) begin
                check_data_flit(node_in_link_o);
            end
        end
    end

    initial begin
        void'($urandom(47806));
        clk             = 1'b0;
        rst_i           = 1'b1;
        rd_cmd_i        = '0;
        rd_cmd_valid_i  = 1'b0;
        wr_cmd_i        = '0;
        wr_cmd_valid_i  = 1'b0;
        wr_data_i       = '0;
        wr_data_valid_i = 1'b0;
        node_in_ready_i = '1;
        build_stimulus();

        fork
            begin
                repeat (total_flits * 20 + 200) @(posedge clk);
                other_cnt++;
                $display("watchdog expired with %0d control and %0d data flits still expected",
                         exp_c_q.size(), exp_d_q.size());
                $display("errors: %0d mismatch, %0d other", mismatch_cnt, other_cnt);
                $display("Simulation failed");
                $finish;
            end
            apply_backpressure();
        join_none

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // idle state right after reset
        if (node_in_valid_o !== '0 || rd_cmd_ready_o !== 1'b1 || wr_cmd_ready_o !== 1'b1) begin
            other_cnt++;
            $display("%0t ns: outputs not idle after reset (valid %b, rd ready %b, wr ready %b)",
                     $time, node_in_valid_o, rd_cmd_ready_o, wr_cmd_ready_o);
        end

        fork
            drive_reads();
            drive_writes();
        join

        while (exp_c_q.size() != 0 || exp_d_q.size() != 0) begin
            @(negedge clk);
        end
        // a few more cycles to catch stray flits
        repeat (10) @(posedge clk);

        $display("errors: %0d mismatch, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
